//--- load_store.f
source/load_store_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/load_store.sv
test/load_store_tb.sv

//--- Makefile
TOP := load_store_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): load_store.f $(wildcard source/*.sv) test/load_store_tb.sv
	verilator --binary --timing --assert --top-module $(TOP) -f load_store.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f load_store.f

clean:
	rm -rf obj_dir

//--- test/load_store_tests.txt
# I = instruction word, E = expected result word, both hex, in program order
# r1 = 0x0035, r2 = 0xfff0, every alu op, then read out
I 3519
I F029
I 2131
I 2142
I 2153
I 2164
I 2175
I 030C
E 0025
I 040C
E 0045
I 050C
E 0030
I 060C
E FFF5
I 070C
E FFC5
# shifts by r8 = 3, addi of -2
I 0389
I 8196
I 82A7
I E1B8
I 090C
E 01A8
I 0A0C
E 1FFE
I 0B0C
E 0033
# dependent chain through both forwarding paths
I 5BC8
I 1CC8
I BCD1
I 0D0C
E 006C
I 7FE9
I 0000
I EEF1
I 0F0C
E 00FE
# store then load, loaded value used at once
I D14B
I 413A
I 3351
I 050C
E 00D8
# writes to r0 are dropped
I 5509
I 1101
I 000C
E 0000

//--- test/load_store_tb.sv
// self-checking testbench for the load-store core, run from the project root to find its tests
`timescale 1ns/1ns

module load_store_tb;

    localparam int clock_period = 100;
    localparam int drive_delay = 10;
    localparam int reset_cycles = 5;
    localparam int cycles_per_line = 40;
    localparam int drain_cycles = 4;

    logic                                  clock;
    logic                                  arst_n;
    logic                                  instr_valid;
    logic                                  instr_ready;
    logic [load_store_pkg::word_width-1:0] instr;
    logic                                  result_valid;
    logic                                  result_ready;
    logic [load_store_pkg::word_width-1:0] result;

    logic [load_store_pkg::word_width-1:0] instr_q [$];
    logic [load_store_pkg::word_width-1:0] expect_q [$];
    int                                    instr_idx;
    int                                    expect_idx;
    int                                    line_count;
    bit                                    loaded;
    logic [31:0]                           lcg_state;

    load_store dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // roughly 70 percent true, upper bits of the generator are the better ones
    task automatic roll(output bit hit);
        lcg_state = lcg_next(lcg_state);
        hit = ({16'd0, lcg_state[31:16]} % 32'd100) < 32'd70;
    endtask

    task automatic load_tests();
        int                                    fd;
        int                                    count;
        string                                 line;
        logic [7:0]                            tag;
        logic [load_store_pkg::word_width-1:0] word;
        fd = $fopen("test/load_store_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/load_store_tests.txt");
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            // anything not tagged I or E is a comment
            while ($fgets(line, fd) > 0) begin
                count = $sscanf(line, "%c %h", tag, word);
                if (count == 2 && tag == "I") begin
                    instr_q.push_back(word);
                    line_count++;
                end else if (count == 2 && tag == "E") begin
                    expect_q.push_back(word);
                    line_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_result();
        if (expect_idx >= expect_q.size()) begin
            $display("a result of %h arrived at %0t with no expected word left", result, $time);
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            assert (result === expect_q[expect_idx]) else begin
                $display("CHECK FAILED time=%0t result got=%h expected=%h",
                         $time, result, expect_q[expect_idx]);
                $display("TEST FAILED");
                $fatal(1);
            end
            expect_idx++;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        wait (loaded);
        repeat (reset_cycles + line_count * cycles_per_line) @(posedge clock);
        $display("timed out with %0d of %0d expected results seen", expect_idx, expect_q.size());
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        bit take_instr;
        bit take_result;
        bit offer;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        result_ready = 1'b0;
        lcg_state = 32'h3a192295;
        instr_idx = 0;
        expect_idx = 0;
        line_count = 0;
        load_tests();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        arst_n = 1'b1;
        while (expect_idx < expect_q.size()) begin
            // handshakes sampled mid-cycle, where every signal has settled
            @(negedge clock);
            take_instr = instr_valid && instr_ready;
            take_result = result_valid && result_ready;
            if (take_result) begin
                check_result();
            end
            @(posedge clock);
            #drive_delay;
            if (take_instr) begin
                instr_idx++;
            end
            // an offered word stays put until it is taken
            if (!instr_valid || take_instr) begin
                roll(offer);
                instr_valid = offer && instr_idx < instr_q.size();
                if (instr_idx < instr_q.size()) begin
                    instr = instr_q[instr_idx];
                end
            end
            roll(offer);
            result_ready = offer;
        end
        // nothing more may come out once every expected word is in
        instr_valid = 1'b0;
        result_ready = 1'b1;
        repeat (drain_cycles) begin
            @(negedge clock);
            if (result_valid) begin
                check_result();
            end
        end
        if (instr_idx == instr_q.size()) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d instructions were accepted", instr_idx, instr_q.size());
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

//--- source/load_store.sv
// top level of the four-stage load-store core, instantiated by the testbench as the DUT
`timescale 1ns/1ns

module load_store (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  instr_valid,
    output logic                                  instr_ready,
    input  logic [load_store_pkg::word_width-1:0] instr,
    output logic                                  result_valid,
    input  logic                                  result_ready,
    output logic [load_store_pkg::word_width-1:0] result
);

    logic [load_store_pkg::reg_addr_width-1:0] rs1_addr;
    logic [load_store_pkg::reg_addr_width-1:0] rs2_addr;
    logic [load_store_pkg::word_width-1:0]     rs1_data;
    logic [load_store_pkg::word_width-1:0]     rs2_data;

    load_store_pkg::hazard_ctrl_t hazard;
    load_store_pkg::decoded_t     decoded;
    load_store_pkg::exec_result_t executed;
    load_store_pkg::writeback_t   writeback;

    decode_stage u_decode (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .hazard      (hazard),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .decoded     (decoded)
    );

    // writeback stage is the register file write port
    register_file u_register_file (
        .clock     (clock),
        .arst_n    (arst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .writeback (writeback)
    );

    execute_stage u_execute (
        .clock    (clock),
        .arst_n   (arst_n),
        .hazard   (hazard),
        .decoded  (decoded),
        .mem_fwd  (executed),
        .wb_fwd   (writeback),
        .executed (executed)
    );

    memory_stage u_memory (
        .clock        (clock),
        .arst_n       (arst_n),
        .hazard       (hazard),
        .executed     (executed),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .writeback    (writeback)
    );

    hazard_unit u_hazard (
        .decode_instr    (instr),
        .execute_decoded (decoded),
        .result_valid    (result_valid),
        .result_ready    (result_ready),
        .hazard          (hazard)
    );

endmodule

//--- source/hazard_unit.sv
// hazard unit: combinational load-use stall and output back-pressure freeze for all stages
`timescale 1ns/1ns

module hazard_unit (
    input  logic [load_store_pkg::word_width-1:0] decode_instr,
    input  load_store_pkg::decoded_t              execute_decoded,
    input  logic                                  result_valid,
    input  logic                                  result_ready,
    output load_store_pkg::hazard_ctrl_t          hazard
);

    load_store_pkg::opcode_e                   op;
    logic [load_store_pkg::reg_addr_width-1:0] rs1;
    logic [load_store_pkg::reg_addr_width-1:0] rs2;
    logic                                      reads_rs1;
    logic                                      reads_rs2;
    logic                                      load_pending;
    logic                                      load_use;

    assign op = load_store_pkg::opcode_e'(decode_instr[3:0]);
    assign rs1 = decode_instr[11:8];
    assign rs2 = decode_instr[15:12];

    // li keeps its immediate in the rs slots
    assign reads_rs1 = op inside {load_store_pkg::op_add, load_store_pkg::op_sub,
                                  load_store_pkg::op_and, load_store_pkg::op_or,
                                  load_store_pkg::op_xor, load_store_pkg::op_sll,
                                  load_store_pkg::op_srl, load_store_pkg::op_addi,
                                  load_store_pkg::op_lw, load_store_pkg::op_sw,
                                  load_store_pkg::op_out};
    assign reads_rs2 = op inside {load_store_pkg::op_add, load_store_pkg::op_sub,
                                  load_store_pkg::op_and, load_store_pkg::op_or,
                                  load_store_pkg::op_xor, load_store_pkg::op_sll,
                                  load_store_pkg::op_srl, load_store_pkg::op_sw};

    assign load_pending = execute_decoded.op == load_store_pkg::op_lw &&
                          execute_decoded.regwrite && execute_decoded.rd != '0;
    assign load_use = load_pending &&
                      ((reads_rs1 && rs1 == execute_decoded.rd) ||
                       (reads_rs2 && rs2 == execute_decoded.rd));

    // freeze wins, the stall shows up once the output drains
    assign hazard.freeze = result_valid && !result_ready;
    assign hazard.stall_decode = load_use && !hazard.freeze;

endmodule

//--- source/memory_stage.sv
// memory stage: data RAM, result port handshake and the writeback register
`timescale 1ns/1ns

module memory_stage (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  load_store_pkg::hazard_ctrl_t          hazard,
    input  load_store_pkg::exec_result_t          executed,
    output logic                                  result_valid,
    input  logic                                  result_ready,
    output logic [load_store_pkg::word_width-1:0] result,
    output load_store_pkg::writeback_t            writeback
);

    localparam int depth = 2**load_store_pkg::mem_addr_width;

    logic [load_store_pkg::word_width-1:0]     ram [depth];
    logic [depth-1:0]                          written;
    logic [load_store_pkg::mem_addr_width-1:0] addr;
    logic [load_store_pkg::word_width-1:0]     ram_data;
    logic                                      store_en;
    logic [load_store_pkg::word_width-1:0]     wb_data;

    assign addr = executed.value[load_store_pkg::mem_addr_width-1:0];

    // store happens as the instruction leaves
    assign store_en = !hazard.freeze && executed.op == load_store_pkg::op_sw;

    // words never stored read back as zero
    assign ram_data = written[addr] ? ram[addr] : '0;

    always_ff @(posedge clock) begin
        if (store_en) begin
            ram[addr] <= executed.store_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            written <= '0;
        end else if (store_en) begin
            written[addr] <= 1'b1;
        end
    end

    assign result_valid = executed.op == load_store_pkg::op_out;
    assign result = executed.value;

    assign wb_data = (executed.op == load_store_pkg::op_lw) ? ram_data : executed.value;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            writeback <= '0;
        end else if (!hazard.freeze) begin
            writeback.rd <= executed.rd;
            writeback.regwrite <= executed.regwrite;
            writeback.data <= wb_data;
        end
    end

    // output held steady under back-pressure
    assert property (@(posedge clock) disable iff (!arst_n)
        result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("result changed while waiting for result_ready");

endmodule

//--- source/execute_stage.sv
// execute stage: operand forwarding, ALU and address generation into the execute register
`timescale 1ns/1ns

module execute_stage (
    input  logic                         clock,
    input  logic                         arst_n,
    input  load_store_pkg::hazard_ctrl_t hazard,
    input  load_store_pkg::decoded_t     decoded,
    input  load_store_pkg::exec_result_t mem_fwd,
    input  load_store_pkg::writeback_t   wb_fwd,
    output load_store_pkg::exec_result_t executed
);

    logic [load_store_pkg::word_width-1:0] op_a;
    logic [load_store_pkg::word_width-1:0] op_b;
    logic [load_store_pkg::word_width-1:0] value;

    // younger memory-stage result beats the writeback one
    function automatic logic [load_store_pkg::word_width-1:0] forward(
        input logic [load_store_pkg::reg_addr_width-1:0] rs,
        input logic [load_store_pkg::word_width-1:0]     reg_value,
        input load_store_pkg::exec_result_t              mem,
        input load_store_pkg::writeback_t                wb
    );
        if (mem.regwrite && mem.rd != '0 && mem.rd == rs) begin
            return mem.value;
        end else if (wb.regwrite && wb.rd != '0 && wb.rd == rs) begin
            return wb.data;
        end
        return reg_value;
    endfunction

    assign op_a = forward(decoded.rs1, decoded.a, mem_fwd, wb_fwd);
    assign op_b = forward(decoded.rs2, decoded.b, mem_fwd, wb_fwd);

    always_comb begin
        case (decoded.op)
            load_store_pkg::op_add:  value = op_a + op_b;
            load_store_pkg::op_sub:  value = op_a - op_b;
            load_store_pkg::op_and:  value = op_a & op_b;
            load_store_pkg::op_or:   value = op_a | op_b;
            load_store_pkg::op_xor:  value = op_a ^ op_b;
            load_store_pkg::op_sll:  value = op_a << op_b[3:0];
            load_store_pkg::op_srl:  value = op_a >> op_b[3:0];
            // immediate adds double as load and store addresses
            load_store_pkg::op_addi,
            load_store_pkg::op_lw,
            load_store_pkg::op_sw:   value = op_a + decoded.imm;
            load_store_pkg::op_li:   value = decoded.imm;
            load_store_pkg::op_out:  value = op_a;
            default:                 value = '0;
        endcase
    end

    // load-use bubbles arrive through the decode register, so only freeze matters here
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            executed <= '0;
        end else if (!hazard.freeze) begin
            executed.op <= decoded.op;
            executed.rd <= decoded.rd;
            executed.regwrite <= decoded.regwrite;
            executed.value <= value;
            executed.store_data <= op_b;
        end
    end

    // a load in memory holds its address and not its data yet
    assert property (@(posedge clock) disable iff (!arst_n)
        mem_fwd.op == load_store_pkg::op_lw && mem_fwd.rd != '0 &&
        !(decoded.op inside {load_store_pkg::op_nop, load_store_pkg::op_li})
        |-> decoded.rs1 != mem_fwd.rd)
    else $error("operand forwarded from a load before its data was read");

endmodule

//--- source/decode_stage.sv
// decode stage: accepts the instruction stream, reads operands, and fills the decode register
`timescale 1ns/1ns

module decode_stage (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  logic                                      instr_valid,
    output logic                                      instr_ready,
    input  logic [load_store_pkg::word_width-1:0]     instr,
    input  load_store_pkg::hazard_ctrl_t              hazard,
    output logic [load_store_pkg::reg_addr_width-1:0] rs1_addr,
    output logic [load_store_pkg::reg_addr_width-1:0] rs2_addr,
    input  logic [load_store_pkg::word_width-1:0]     rs1_data,
    input  logic [load_store_pkg::word_width-1:0]     rs2_data,
    output load_store_pkg::decoded_t                  decoded
);

    load_store_pkg::opcode_e               op;
    logic [load_store_pkg::word_width-1:0] imm;
    logic                                  regwrite;
    logic                                  accept;
    load_store_pkg::decoded_t              next_decoded;

    assign op = load_store_pkg::opcode_e'(instr[3:0]);
    assign rs1_addr = instr[11:8];
    assign rs2_addr = instr[15:12];

    assign instr_ready = !(hazard.stall_decode || hazard.freeze);
    assign accept = instr_valid && instr_ready;

    // immediate format depends on the opcode
    always_comb begin
        case (op)
            load_store_pkg::op_li:
                imm = {{8{instr[15]}}, instr[15:8]};
            load_store_pkg::op_addi,
            load_store_pkg::op_lw:
                imm = {{12{instr[15]}}, instr[15:12]};
            // store keeps its offset in the rd slot
            load_store_pkg::op_sw:
                imm = {{12{instr[7]}}, instr[7:4]};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        case (op)
            load_store_pkg::op_add,
            load_store_pkg::op_sub,
            load_store_pkg::op_and,
            load_store_pkg::op_or,
            load_store_pkg::op_xor,
            load_store_pkg::op_sll,
            load_store_pkg::op_srl,
            load_store_pkg::op_addi,
            load_store_pkg::op_li,
            load_store_pkg::op_lw:
                regwrite = 1'b1;
            default:
                regwrite = 1'b0;
        endcase
    end

    always_comb begin
        next_decoded.op = op;
        next_decoded.rd = instr[7:4];
        next_decoded.rs1 = rs1_addr;
        next_decoded.rs2 = rs2_addr;
        next_decoded.imm = imm;
        next_decoded.a = rs1_data;
        next_decoded.b = rs2_data;
        next_decoded.regwrite = regwrite;
    end

    // freeze holds, otherwise a bubble unless an instruction is taken
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else if (!hazard.freeze) begin
            if (accept) begin
                decoded <= next_decoded;
            end else begin
                decoded <= '0;
            end
        end
    end

    // an accepted word must carry a known opcode all the way into execute
    assert property (@(posedge clock) disable iff (!arst_n)
        accept |=> decoded.op <= 4'(load_store_pkg::op_out))
    else $error("illegal opcode entered the pipeline");

endmodule

//--- source/register_file.sv
// sixteen-entry register file with write-through reads, written by the writeback stage
`timescale 1ns/1ns

module register_file (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  logic [load_store_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [load_store_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [load_store_pkg::word_width-1:0]     rs1_data,
    output logic [load_store_pkg::word_width-1:0]     rs2_data,
    input  load_store_pkg::writeback_t                writeback
);

    logic [load_store_pkg::word_width-1:0] regs [2**load_store_pkg::reg_addr_width];

    // r0 reads zero, same-cycle write is passed straight through
    function automatic logic [load_store_pkg::word_width-1:0] read_port(
        input logic [load_store_pkg::reg_addr_width-1:0] addr,
        input load_store_pkg::writeback_t               wb,
        input logic [load_store_pkg::word_width-1:0]     stored
    );
        if (addr == '0) begin
            return '0;
        end else if (wb.regwrite && wb.rd == addr) begin
            return wb.data;
        end
        return stored;
    endfunction

    assign rs1_data = read_port(rs1_addr, writeback, regs[rs1_addr]);
    assign rs2_data = read_port(rs2_addr, writeback, regs[rs2_addr]);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**load_store_pkg::reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback.regwrite && writeback.rd != '0) begin
            regs[writeback.rd] <= writeback.data;
        end
    end

endmodule

//--- source/load_store_pkg.sv
// widths, opcodes and pipeline structs shared by every stage of the load-store core
package load_store_pkg;

    localparam int word_width = 16;
    localparam int reg_addr_width = 4;
    localparam int mem_addr_width = 8;
    localparam int opcode_width = 4;

    // opcode sits in instruction bits 3..0
    typedef enum logic [opcode_width-1:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_sll  = 4'd6,
        op_srl  = 4'd7,
        op_addi = 4'd8,
        op_li   = 4'd9,
        op_lw   = 4'd10,
        op_sw   = 4'd11,
        op_out  = 4'd12
    } opcode_e;

    // decode to execute
    typedef struct packed {
        opcode_e                   op;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [word_width-1:0]     imm;
        logic [word_width-1:0]     a;
        logic [word_width-1:0]     b;
        logic                      regwrite;
    } decoded_t;

    // execute to memory, value is alu result or address
    typedef struct packed {
        opcode_e                   op;
        logic [reg_addr_width-1:0] rd;
        logic                      regwrite;
        logic [word_width-1:0]     value;
        logic [word_width-1:0]     store_data;
    } exec_result_t;

    // memory to writeback, also the older forwarding source
    typedef struct packed {
        logic [reg_addr_width-1:0] rd;
        logic                      regwrite;
        logic [word_width-1:0]     data;
    } writeback_t;

    typedef struct packed {
        logic stall_decode;
        logic freeze;
    } hazard_ctrl_t;

endpackage
